// ==== common/mcu_io_pkg.sv ====
package mcu_io_pkg;

    // bank sizes
    localparam int NUM_REGS        = 16;
    localparam int NUM_DATA_INPUTS = 16;
    localparam int WORD_WIDTH      = 16;

    // apb byte address with word n at 4*n
    localparam int ADDR_WIDTH = 8;

    // word index; msb set selects the data input bank
    localparam int INDEX_WIDTH = 5;
    // index bits below the bank select
    localparam int SEL_WIDTH   = 4;

    // output register slots
    localparam int REG_LED       = 0;
    localparam int REG_ANMUX     = 1;
    localparam int REG_UART_DATA = 8;
    localparam int REG_UART_LOAD = 9;

    // data input slots
    localparam int DIN_UART_BUSY = 0;
    localparam int DIN_KEYS      = 1;

    // dg408 analog mux control word
    // raw for host access, f for the pin decode
    typedef union packed {
        logic [WORD_WIDTH-1:0] raw;
        struct packed {
            logic [WORD_WIDTH-5:0] rsvd;
            logic                  en;
            logic [2:0]            a;
        } f;
    } anmux_word_u;

endpackage

// ==== common/uart_pkg.sv ====
package uart_pkg;

    // 8N1 framing
    localparam int DATA_BITS  = 8;
    // start + data + stop
    localparam int FRAME_BITS = DATA_BITS + 2;

    // sample tick at 4x the bit rate
    localparam int SAMPLES_PER_BIT = 4;
    // 50 MHz / 108 / 4 gives roughly 115200 bit/s
    localparam int CLKS_PER_SAMPLE = 108;
    localparam int CLKS_PER_BIT    = CLKS_PER_SAMPLE * SAMPLES_PER_BIT;

    // counter widths for the transmitter
    localparam int DIV_WIDTH    = $clog2(CLKS_PER_SAMPLE);
    localparam int SAMPLE_WIDTH = $clog2(SAMPLES_PER_BIT);
    localparam int BITCNT_WIDTH = $clog2(FRAME_BITS);

endpackage

// ==== common/reg_access_if.sv ====
`timescale 1ns/1ps

interface reg_access_if;

    // request side from the bus bridge
    logic                               acc_valid;
    logic                               acc_write;
    logic [mcu_io_pkg::INDEX_WIDTH-1:0] acc_index;
    logic [mcu_io_pkg::WORD_WIDTH-1:0]  acc_wdata;

    // combinational response on acc_index
    logic [mcu_io_pkg::WORD_WIDTH-1:0]  acc_rdata;
    // write into the read-only bank
    logic                               acc_err;

    modport bridge (
        output acc_valid, acc_write, acc_index, acc_wdata,
        input  acc_rdata, acc_err
    );

    modport regs (
        input  acc_valid, acc_write, acc_index, acc_wdata,
        output acc_rdata, acc_err
    );

endinterface

// ==== hdl/apb_bridge.sv ====
`timescale 1ns/1ps

module apb_bridge (
    input  logic                              clk50m,
    input  logic                              rst,
    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  logic [mcu_io_pkg::ADDR_WIDTH-1:0] paddr,
    input  logic [mcu_io_pkg::WORD_WIDTH-1:0] pwdata,
    output logic [mcu_io_pkg::WORD_WIDTH-1:0] prdata,
    output logic                              pready,
    output logic                              pslverr,
    reg_access_if.bridge                      acc
);

    // high during the second access cycle
    logic done_q;
    // first access cycle of a transfer
    logic access_start;
    // address outside the map or not word aligned
    logic addr_bad;

    assign access_start = psel & penable & ~done_q;

    // bits above the word index and the byte lanes must be clear
    assign addr_bad = (|paddr[mcu_io_pkg::ADDR_WIDTH-1:mcu_io_pkg::INDEX_WIDTH+2])
                    | (|paddr[1:0]);

    // request toward the register bank
    assign acc.acc_valid = access_start & ~addr_bad;
    assign acc.acc_write = pwrite;
    assign acc.acc_index = paddr[mcu_io_pkg::INDEX_WIDTH+1:2];
    assign acc.acc_wdata = pwdata;

    // completion one cycle after the strobe
    assign pready = done_q;

    always_ff @(posedge clk50m) begin
        if (rst) begin
            done_q  <= 1'b0;
            pslverr <= 1'b0;
        end else if (done_q) begin
            // transfer completes this cycle
            done_q  <= 1'b0;
            pslverr <= 1'b0;
        end else if (access_start) begin
            done_q  <= 1'b1;
            // bad address or read-only write
            pslverr <= addr_bad | acc.acc_err;
        end
    end

    // read word captured alongside the strobe
    always_ff @(posedge clk50m) begin
        if (access_start) begin
            prdata <= acc.acc_rdata;
        end
    end

endmodule

// ==== hdl/io_regfile.sv ====
`timescale 1ns/1ps

module io_regfile (
    input  logic             clk50m,
    input  logic             rst,
    input  logic [1:0]       keys,
    input  logic             tx_busy,
    reg_access_if.regs       acc,
    output logic [7:0]       led,
    output logic             anmux_en,
    output logic [2:0]       anmux_a,
    output logic [7:0]       tx_data,
    output logic             tx_start
);

    // output register bank
    logic [mcu_io_pkg::WORD_WIDTH-1:0] regs_q [mcu_io_pkg::NUM_REGS];
    // data input bank, assembled from live signals
    logic [mcu_io_pkg::WORD_WIDTH-1:0] din [mcu_io_pkg::NUM_DATA_INPUTS];

    // slot within the selected bank
    logic [mcu_io_pkg::SEL_WIDTH-1:0] sel;
    // msb of the index picks the input bank
    logic                             in_bank;
    logic                             wr_en;
    logic                             load_hit;

    mcu_io_pkg::anmux_word_u anmux_w;

    assign sel     = acc.acc_index[mcu_io_pkg::SEL_WIDTH-1:0];
    assign in_bank = acc.acc_index[mcu_io_pkg::INDEX_WIDTH-1];

    // only the output bank is writable
    assign wr_en = acc.acc_valid & acc.acc_write & ~in_bank;

    // load register with bit 0 set kicks the transmitter
    assign load_hit = (sel == mcu_io_pkg::SEL_WIDTH'(mcu_io_pkg::REG_UART_LOAD))
                    & acc.acc_wdata[0];

    // writes into the input bank are flagged, not performed
    assign acc.acc_err = acc.acc_write & in_bank;

    // busy flag and keys with zeros elsewhere
    always_comb begin
        for (int i = 0; i < mcu_io_pkg::NUM_DATA_INPUTS; i++) begin
            din[i] = '0;
        end
        din[mcu_io_pkg::DIN_UART_BUSY] = mcu_io_pkg::WORD_WIDTH'(tx_busy);
        din[mcu_io_pkg::DIN_KEYS]      = mcu_io_pkg::WORD_WIDTH'(keys);
    end

    // read mux over both banks
    always_comb begin
        if (in_bank) begin
            acc.acc_rdata = din[sel];
        end else begin
            acc.acc_rdata = regs_q[sel];
        end
    end

    always_ff @(posedge clk50m) begin
        if (rst) begin
            for (int i = 0; i < mcu_io_pkg::NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
            tx_start <= 1'b0;
        end else begin
            // single cycle pulse by default
            tx_start <= 1'b0;
            if (wr_en) begin
                // load register also stored as written
                regs_q[sel] <= acc.acc_wdata;
                if (load_hit) begin
                    tx_start <= 1'b1;
                end
            end
        end
    end

    // led pins from the low byte
    assign led = regs_q[mcu_io_pkg::REG_LED][7:0];

    // mux word decoded through the field view
    always_comb begin
        anmux_w.raw = regs_q[mcu_io_pkg::REG_ANMUX];
    end
    assign anmux_en = anmux_w.f.en;
    assign anmux_a  = anmux_w.f.a;

    // transmit byte
    assign tx_data = regs_q[mcu_io_pkg::REG_UART_DATA][7:0];

endmodule

// ==== uart/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx (
    input  logic                           clk50m,
    input  logic                           rst,
    input  logic [uart_pkg::DATA_BITS-1:0] tx_data,
    input  logic                           tx_start,
    output logic                           tx_line,
    output logic                           tx_busy
);

    // clk50m cycles within one sample period
    logic [uart_pkg::DIV_WIDTH-1:0]    div_cnt;
    // sample ticks within one bit
    logic [uart_pkg::SAMPLE_WIDTH-1:0] samp_cnt;
    // bit currently on the line
    logic [uart_pkg::BITCNT_WIDTH-1:0] bit_cnt;
    // framed byte, lsb goes out first
    logic [uart_pkg::FRAME_BITS-1:0]   shift_q;

    logic tick;
    logic bit_end;
    logic last_bit;

    // 4x sample tick
    assign tick = (div_cnt == uart_pkg::DIV_WIDTH'(uart_pkg::CLKS_PER_SAMPLE - 1));
    // last tick of a bit period
    assign bit_end = tick
                   & (samp_cnt == uart_pkg::SAMPLE_WIDTH'(uart_pkg::SAMPLES_PER_BIT - 1));
    // stop bit on the line
    assign last_bit = (bit_cnt == uart_pkg::BITCNT_WIDTH'(uart_pkg::FRAME_BITS - 1));

    // idle high, start bit low as soon as the frame loads
    assign tx_line = shift_q[0];

    always_ff @(posedge clk50m) begin
        if (rst) begin
            tx_busy  <= 1'b0;
            shift_q  <= '1;
            div_cnt  <= '0;
            samp_cnt <= '0;
            bit_cnt  <= '0;
        end else if (!tx_busy) begin
            // start only accepted while idle
            if (tx_start) begin
                tx_busy  <= 1'b1;
                // stop, data, start
                shift_q  <= {1'b1, tx_data, 1'b0};
                // divider restarts at the start edge
                div_cnt  <= '0;
                samp_cnt <= '0;
                bit_cnt  <= '0;
            end
        end else begin
            if (tick) begin
                div_cnt  <= '0;
                samp_cnt <= samp_cnt + 1'b1;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
            if (bit_end) begin
                // shift in ones so the line idles high after the stop bit
                shift_q <= {1'b1, shift_q[uart_pkg::FRAME_BITS-1:1]};
                if (last_bit) begin
                    tx_busy <= 1'b0;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

endmodule

// ==== hdl/mcu_io_top.sv ====
`timescale 1ns/1ps

module mcu_io_top (
    input  logic                              clk50m,
    input  logic                              rst,

    // apb completer standing in for the cpu core
    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  logic [mcu_io_pkg::ADDR_WIDTH-1:0] paddr,
    input  logic [mcu_io_pkg::WORD_WIDTH-1:0] pwdata,
    output logic [mcu_io_pkg::WORD_WIDTH-1:0] prdata,
    output logic                              pready,
    output logic                              pslverr,

    // board pins
    input  logic [1:0]                        KEY,
    output logic [7:0]                        LED,
    output logic [12:0]                       GPIO_2
);

    logic       anmux_en;
    logic [2:0] anmux_a;
    logic [7:0] tx_data;
    logic       tx_start;
    logic       tx_busy;
    logic       tx_line;

    reg_access_if acc_if ();

    apb_bridge i_apb_bridge (
        .clk50m  (clk50m),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .acc     (acc_if.bridge)
    );

    io_regfile i_io_regfile (
        .clk50m   (clk50m),
        .rst      (rst),
        .keys     (KEY),
        .tx_busy  (tx_busy),
        .acc      (acc_if.regs),
        .led      (LED),
        .anmux_en (anmux_en),
        .anmux_a  (anmux_a),
        .tx_data  (tx_data),
        .tx_start (tx_start)
    );

    // 8N1 transmitter on the board clock
    uart_tx i_uart_tx (
        .clk50m   (clk50m),
        .rst      (rst),
        .tx_data  (tx_data),
        .tx_start (tx_start),
        .tx_line  (tx_line),
        .tx_busy  (tx_busy)
    );

    // dg408 pins on the 2x13 header
    // en on bit 3, a2 on bit 2, a1 and a0 swapped on bits 0 and 1
    assign GPIO_2[3] = anmux_en;
    assign GPIO_2[2] = anmux_a[2];
    assign GPIO_2[0] = anmux_a[1];
    assign GPIO_2[1] = anmux_a[0];

    // uart tx pin
    assign GPIO_2[11] = tx_line;

    // no other header functions
    assign GPIO_2[10:4] = '0;
    assign GPIO_2[12]   = 1'b0;

endmodule

// ==== testbench/tb_mcu_io_top.sv ====
`timescale 1ns/1ps

module tb_mcu_io_top;

    localparam int BIT_CLKS   = uart_pkg::CLKS_PER_BIT;
    localparam int FRAME_CLKS = uart_pkg::FRAME_BITS * uart_pkg::CLKS_PER_BIT;

    // one apb transfer with its expected response and pin state
    typedef struct packed {
        logic        write;
        logic [7:0]  addr;
        logic [15:0] wdata;
        logic [15:0] exp_rdata;
        logic        exp_err;
        logic [1:0]  key;
        logic [7:0]  exp_led;
        logic [12:0] exp_gpio;
    } row_t;

    logic        clk50m = 1'b0;
    logic        rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [15:0] pwdata;
    logic [15:0] prdata;
    logic        pready;
    logic        pslverr;
    logic [1:0]  KEY;
    logic [7:0]  LED;
    logic [12:0] GPIO_2;

    row_t        rows[$];
    // expected output bank while the table is built
    logic [15:0] shadow [16] = '{default: 16'h0000};
    // out of map and misaligned byte addresses
    logic [7:0]  bad_addrs [7] = '{8'h80, 8'h84, 8'hC4, 8'hFC, 8'h01, 8'h06, 8'h4B};
    logic [7:0]  uart_bytes [2] = '{8'hA5, 8'h3C};
    int          seed = 95680;
    int          errors = 0;
    int          checks = 0;
    int          cyc = 0;
    logic        timed_out = 1'b0;

    mcu_io_top i_dut (
        .clk50m  (clk50m),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .KEY     (KEY),
        .LED     (LED),
        .GPIO_2  (GPIO_2)
    );

    // 4 ns period
    always #2 clk50m = ~clk50m;

    // free running cycle count for uart bit timing
    always @(posedge clk50m) cyc <= cyc + 1;

    task automatic check_eq(input string name, input logic [15:0] exp, input logic [15:0] act);
        checks++;
        assert (act === exp) else begin
            $display("[FAIL] time %0t %s expected 0x%h got 0x%h", $time, name, exp, act);
            errors++;
        end
    endtask

    // setup cycle, then access until pready
    task automatic apb_transfer(input logic wr, input logic [7:0] addr, input logic [15:0] wdata,
                                output logic [15:0] rdata, output logic err);
        int n;
        @(posedge clk50m);
        #0.5;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk50m);
        #0.5;
        penable = 1'b1;
        n = 0;
        // sample on the falling edge
        @(negedge clk50m);
        // one wait state in the first access cycle
        check_eq("pready in first access cycle", 16'd0, 16'(pready));
        while (!pready && n < 10) begin
            @(negedge clk50m);
            n++;
        end
        if (!pready) begin
            $display("timeout: no pready within 10 cycles at address 0x%h", addr);
            timed_out = 1'b1;
        end else begin
            check_eq("pready wait cycles", 16'd1, 16'(n));
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk50m);
        #0.5;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // park on the negedge where the cycle count reaches target
    task automatic wait_cycle(input int target);
        int n;
        n = 0;
        while (cyc < target && n < FRAME_CLKS) begin
            @(negedge clk50m);
            n++;
        end
        if (cyc < target) begin
            $display("timeout: cycle %0d never reached", target);
            timed_out = 1'b1;
        end
    endtask

    // header pins for a mux word with the uart line idle
    function automatic logic [12:0] mux_pins(input logic [15:0] w);
        mcu_io_pkg::anmux_word_u u;
        logic [12:0]             g;
        u.raw = w;
        g     = 13'h0000;
        g[3]  = u.f.en;
        g[2]  = u.f.a[2];
        g[0]  = u.f.a[1];
        g[1]  = u.f.a[0];
        g[11] = 1'b1;
        return g;
    endfunction

    function automatic void add_row(input logic wr, input logic [7:0] addr,
                                    input logic [15:0] wdata, input logic [15:0] exp,
                                    input logic err, input logic [1:0] key);
        row_t r;
        // accepted writes land in the output bank
        if (wr && !err) begin
            shadow[addr[5:2]] = wdata;
        end
        r.write     = wr;
        r.addr      = addr;
        r.wdata     = wdata;
        r.exp_rdata = exp;
        r.exp_err   = err;
        r.key       = key;
        r.exp_led   = shadow[0][7:0];
        r.exp_gpio  = mux_pins(shadow[1]);
        rows.push_back(r);
    endfunction

    function automatic void build_table();
        logic [15:0]             w;
        mcu_io_pkg::anmux_word_u u;
        // read-back with bit 0 of the load register clear
        for (int i = 0; i < 16; i++) begin
            w = 16'($random(seed));
            if (i == mcu_io_pkg::REG_UART_LOAD) begin
                w[0] = 1'b0;
            end
            add_row(1'b1, 8'(i * 4), w, 16'h0000, 1'b0, 2'd0);
            add_row(1'b0, 8'(i * 4), 16'h0000, w, 1'b0, 2'd0);
        end
        // all en and address combinations with junk in the reserved bits
        for (int c = 0; c < 16; c++) begin
            u.raw  = 16'($random(seed));
            u.f.en = c[3];
            u.f.a  = c[2:0];
            add_row(1'b1, 8'(mcu_io_pkg::REG_ANMUX * 4), u.raw, 16'h0000, 1'b0, 2'd0);
        end
        // keys on data input 1
        for (int k = 0; k < 4; k++) begin
            add_row(1'b0, 8'(17 * 4), 16'h0000, 16'(k), 1'b0, 2'(k));
        end
        // idle busy flag and unused inputs
        for (int i = 16; i < 32; i++) begin
            if (i != 17) begin
                add_row(1'b0, 8'(i * 4), 16'h0000, 16'h0000, 1'b0, 2'd0);
            end
        end
        // input bank is read only
        for (int i = 16; i < 32; i++) begin
            add_row(1'b1, 8'(i * 4), 16'($random(seed)), 16'h0000, 1'b1, 2'd0);
        end
        foreach (bad_addrs[i]) begin
            add_row(1'b1, bad_addrs[i], 16'($random(seed)), 16'h0000, 1'b1, 2'd0);
        end
        add_row(1'b0, 8'h80, 16'h0000, 16'h0000, 1'b1, 2'd0);
        // bank unchanged by all the rejected writes
        for (int i = 0; i < 16; i++) begin
            add_row(1'b0, 8'(i * 4), 16'h0000, shadow[i], 1'b0, 2'd0);
        end
    endfunction

    task automatic run_table();
        logic [15:0] rd;
        logic        err;
        foreach (rows[i]) begin
            if (!timed_out) begin
                KEY = rows[i].key;
                apb_transfer(rows[i].write, rows[i].addr, rows[i].wdata, rd, err);
                check_eq($sformatf("pslverr @0x%h", rows[i].addr), 16'(rows[i].exp_err),
                         16'(err));
                if (!rows[i].write && !rows[i].exp_err) begin
                    check_eq($sformatf("prdata @0x%h", rows[i].addr), rows[i].exp_rdata, rd);
                end
                check_eq("LED", 16'(rows[i].exp_led), 16'(LED));
                check_eq("GPIO_2", 16'(rows[i].exp_gpio), 16'(GPIO_2));
            end
        end
    endtask

    task automatic uart_frame(input logic [7:0] tx_byte);
        logic [15:0]                     rd;
        logic                            err;
        logic [uart_pkg::FRAME_BITS-1:0] frame;
        int                              n;
        int                              t0;
        int                              lows;
        // start low, data lsb first, stop high
        frame = {1'b1, tx_byte, 1'b0};
        check_eq("GPIO_2[11] idle", 16'd1, 16'(GPIO_2[11]));
        apb_transfer(1'b1, 8'(mcu_io_pkg::REG_UART_DATA * 4), 16'(tx_byte), rd, err);
        apb_transfer(1'b1, 8'(mcu_io_pkg::REG_UART_LOAD * 4), 16'd1, rd, err);
        n = 0;
        @(negedge clk50m);
        while (GPIO_2[11] !== 1'b0 && n < 2 * BIT_CLKS) begin
            @(negedge clk50m);
            n++;
        end
        if (GPIO_2[11] !== 1'b0) begin
            $display("timeout: no start bit on GPIO_2[11] for byte 0x%h", tx_byte);
            timed_out = 1'b1;
            return;
        end
        // line fell at the posedge counted into t0
        t0 = cyc;
        apb_transfer(1'b0, 8'(16 * 4), 16'h0000, rd, err);
        check_eq("busy during frame", 16'd1, rd);
        // a second load while busy must not start another frame
        apb_transfer(1'b1, 8'(mcu_io_pkg::REG_UART_LOAD * 4), 16'd1, rd, err);
        for (int b = 0; b < uart_pkg::FRAME_BITS; b++) begin
            wait_cycle(t0 + BIT_CLKS / 2 + b * BIT_CLKS);
            check_eq($sformatf("GPIO_2[11] bit %0d", b), 16'(frame[b]), 16'(GPIO_2[11]));
        end
        wait_cycle(t0 + FRAME_CLKS + 8);
        apb_transfer(1'b0, 8'(16 * 4), 16'h0000, rd, err);
        check_eq("busy after frame", 16'd0, rd);
        // line stays idle after a single frame
        lows = 0;
        for (int j = 0; j < 2 * BIT_CLKS; j++) begin
            @(negedge clk50m);
            if (GPIO_2[11] !== 1'b1) begin
                lows++;
            end
        end
        check_eq("GPIO_2[11] low samples after frame", 16'd0, 16'(lows));
    endtask

    initial begin
        rst     = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = 8'h00;
        pwdata  = 16'h0000;
        KEY     = 2'd0;
        build_table();
        repeat (5) @(posedge clk50m);
        #0.5;
        rst = 1'b0;
        // bus quiet, pins low and uart idle high after reset
        check_eq("pready", 16'd0, 16'(pready));
        check_eq("pslverr", 16'd0, 16'(pslverr));
        check_eq("LED", 16'd0, 16'(LED));
        check_eq("GPIO_2", 16'h0800, 16'(GPIO_2));
        run_table();
        foreach (uart_bytes[i]) begin
            if (!timed_out) begin
                uart_frame(uart_bytes[i]);
            end
        end
        $display("checks %0d, errors %0d, timeout %0d", checks, errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
common/mcu_io_pkg.sv
common/uart_pkg.sv
common/reg_access_if.sv
hdl/apb_bridge.sv
hdl/io_regfile.sv
uart/uart_tx.sv
hdl/mcu_io_top.sv
testbench/tb_mcu_io_top.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_mcu_io_top \
    -f sources.f \
    -Mdir obj_dir -o tb_mcu_io_top

./obj_dir/tb_mcu_io_top > sim.log
cat sim.log

if grep -q "^TEST OK$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
